/* lc3b_types.sv */
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word; // Data and address width.

	// Opcode values follow the LC-3b encoding.
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001,
		op_ldr = 4'b0110,
		op_str = 4'b0111
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass // Routes the address adders.
	} lc3b_aluop;

	// An all-zero word is a bubble and does nothing.
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_aluop  aluop;
		logic       sr2_imm;      // Second operand is imm5.
		logic       mem_read;
		logic       mem_write;
		logic       load_regfile;
		logic       load_cc;
		logic       is_branch;
		logic [2:0] dest;
	} lc3b_control;

	typedef struct packed {
		lc3b_word ir;
		lc3b_word pc;
	} if_id_payload;

	typedef struct packed {
		lc3b_word    ir;
		lc3b_word    pc;
		lc3b_control ctrl;
		lc3b_word    sr1;
		lc3b_word    sr2;
	} id_ex_payload;

	typedef struct packed {
		lc3b_word    ir;
		lc3b_word    pc;
		lc3b_control ctrl;
		lc3b_word    alu;
		lc3b_word    store_data;
	} ex_mem_payload;

	typedef struct packed {
		lc3b_word    ir;
		lc3b_word    pc;
		lc3b_control ctrl;
		lc3b_word    alu;
		lc3b_word    mdr;
	} mem_wb_payload;

endpackage : lc3b_types

`default_nettype wire

/* pipe_latch.sv */
`timescale 1ns/1ps
`default_nettype none

// Stage boundary register, shared by all four pipeline boundaries.
module pipe_latch #(
	parameter type payload_t = logic
) (
	input wire clk,
	input wire reset,
	input wire flush,
	input wire payload_t d,
	output payload_t q
);

	always_ff @(posedge clk) begin
		if (reset || flush)
			q <= '0; // Zero payload is an inert bubble.
		else
			q <= d;
	end

endmodule : pipe_latch

`default_nettype wire

/* instruction_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch #(
	parameter lc3b_types::lc3b_word reset_pc = 16'h0000
) (
	input wire clk,
	input wire reset,
	input wire branch_enable,
	input wire lc3b_types::lc3b_word branch_target,
	output lc3b_types::lc3b_word pc
);

	import lc3b_types::*;

	lc3b_word next_pc;

	// Taken branch overrides the sequential step.
	always_comb begin
		if (branch_enable)
			next_pc = branch_target;
		else
			next_pc = pc + 16'd2;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= reset_pc;
		else
			pc <= next_pc;
	end

endmodule : instruction_fetch

`default_nettype wire

/* instruction_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_decode (
	input wire clk,
	input wire reset,
	input wire lc3b_types::if_id_payload if_id,
	input wire reg_we,
	input wire [2:0] reg_dest,
	input wire lc3b_types::lc3b_word reg_wdata,
	output lc3b_types::id_ex_payload id_ex
);

	import lc3b_types::*;

	lc3b_word    regs [8];
	lc3b_word    ir;
	lc3b_opcode  opcode;
	lc3b_control ctrl;
	logic [2:0]  sr1_idx;
	logic [2:0]  sr2_idx;
	lc3b_word    sr1_val;
	lc3b_word    sr2_val;

	assign ir      = if_id.ir;
	assign opcode  = lc3b_opcode'(ir[15:12]);
	assign sr1_idx = ir[8:6];
	assign sr2_idx = (opcode == op_str) ? ir[11:9] : ir[2:0]; // STR reads its source here.

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (reg_we) begin
			regs[reg_dest] <= reg_wdata;
		end
	end

	// Same-cycle write is seen by the read ports.
	always_comb begin
		sr1_val = regs[sr1_idx];
		if (reg_we && reg_dest == sr1_idx)
			sr1_val = reg_wdata;
		sr2_val = regs[sr2_idx];
		if (reg_we && reg_dest == sr2_idx)
			sr2_val = reg_wdata;
	end

	always_comb begin
		ctrl = '0; // Unsupported opcodes decode to a bubble.
		unique case (opcode)
			op_add, op_and: begin
				ctrl.opcode       = opcode;
				ctrl.aluop        = (opcode == op_add) ? alu_add : alu_and;
				ctrl.sr2_imm      = ir[5];
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc      = 1'b1;
				ctrl.dest         = ir[11:9];
			end
			op_not: begin
				ctrl.opcode       = op_not;
				ctrl.aluop        = alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc      = 1'b1;
				ctrl.dest         = ir[11:9];
			end
			op_ldr: begin
				ctrl.opcode       = op_ldr;
				ctrl.aluop        = alu_pass;
				ctrl.mem_read     = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc      = 1'b1;
				ctrl.dest         = ir[11:9];
			end
			op_str: begin
				ctrl.opcode    = op_str;
				ctrl.aluop     = alu_pass;
				ctrl.mem_write = 1'b1;
			end
			op_br: begin
				ctrl.opcode    = op_br;
				ctrl.aluop     = alu_pass;
				ctrl.is_branch = 1'b1; // nzp 000 never fires, so this doubles as NOP.
			end
			default: ctrl = '0;
		endcase
	end

	always_comb begin
		id_ex.ir   = ir;
		id_ex.pc   = if_id.pc;
		id_ex.ctrl = ctrl;
		id_ex.sr1  = sr1_val;
		id_ex.sr2  = sr2_val;
	end

endmodule : instruction_decode

`default_nettype wire

/* execution_module.sv */
`timescale 1ns/1ps
`default_nettype none

module execution_module (
	input wire lc3b_types::id_ex_payload id_ex,
	output lc3b_types::ex_mem_payload ex_mem
);

	import lc3b_types::*;

	lc3b_word ir;
	lc3b_word imm5;
	lc3b_word off6;
	lc3b_word off9;
	lc3b_word operand_b;
	lc3b_word mem_addr;
	lc3b_word br_addr;
	lc3b_word result;

	assign ir   = id_ex.ir;
	assign imm5 = {{11{ir[4]}}, ir[4:0]};
	assign off6 = {{9{ir[5]}}, ir[5:0], 1'b0}; // Word offset, scaled to bytes.
	assign off9 = {{6{ir[8]}}, ir[8:0], 1'b0};

	assign operand_b = id_ex.ctrl.sr2_imm ? imm5 : id_ex.sr2;

	assign mem_addr = id_ex.sr1 + off6; // Base plus offset6.
	assign br_addr  = id_ex.pc + 16'd2 + off9; // Relative to the next PC.

	always_comb begin
		unique case (id_ex.ctrl.aluop)
			alu_add:  result = id_ex.sr1 + operand_b;
			alu_and:  result = id_ex.sr1 & operand_b;
			alu_not:  result = ~id_ex.sr1;
			alu_pass: result = id_ex.ctrl.is_branch ? br_addr : mem_addr;
			default:  result = '0;
		endcase
	end

	always_comb begin
		ex_mem.ir         = ir;
		ex_mem.pc         = id_ex.pc;
		ex_mem.ctrl       = id_ex.ctrl;
		ex_mem.alu        = result;
		ex_mem.store_data = id_ex.sr2;
	end

endmodule : execution_module

`default_nettype wire

/* memory_module.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_module (
	input wire lc3b_types::ex_mem_payload ex_mem,
	input wire lc3b_types::lc3b_word mem_rdata2,
	output lc3b_types::lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	output lc3b_types::lc3b_word mem_wdata2,
	output lc3b_types::mem_wb_payload mem_wb
);

	import lc3b_types::*;

	// Address always comes from the ALU field.
	assign mem_addr2  = ex_mem.alu;
	assign mem_read2  = ex_mem.ctrl.mem_read;
	assign mem_write2 = ex_mem.ctrl.mem_write;
	assign mem_wdata2 = ex_mem.store_data;

	always_comb begin
		mem_wb.ir   = ex_mem.ir;
		mem_wb.pc   = ex_mem.pc;
		mem_wb.ctrl = ex_mem.ctrl;
		mem_wb.alu  = ex_mem.alu;
		mem_wb.mdr  = ex_mem.ctrl.mem_read ? mem_rdata2 : '0; // Only loads fill the MDR.
	end

endmodule : memory_module

`default_nettype wire

/* writeback_module.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_module (
	input wire clk,
	input wire reset,
	input wire lc3b_types::mem_wb_payload mem_wb,
	output logic reg_we,
	output logic [2:0] reg_dest,
	output lc3b_types::lc3b_word reg_wdata,
	output logic branch_enable,
	output lc3b_types::lc3b_word branch_target,
	output logic flush
);

	import lc3b_types::*;

	logic [2:0] nzp; // Condition codes, n z p from high to low.
	logic [2:0] new_nzp;

	assign reg_wdata = mem_wb.ctrl.mem_read ? mem_wb.mdr : mem_wb.alu;
	assign reg_we    = mem_wb.ctrl.load_regfile;
	assign reg_dest  = mem_wb.ctrl.dest;

	// Sign and zero test of the value being written.
	assign new_nzp = reg_wdata[15] ? 3'b100 : (reg_wdata == '0) ? 3'b010 : 3'b001;

	always_ff @(posedge clk) begin
		if (reset)
			nzp <= 3'b010;
		else if (mem_wb.ctrl.load_cc)
			nzp <= new_nzp;
	end

	assign branch_enable = mem_wb.ctrl.is_branch && |(mem_wb.ir[11:9] & nzp);
	assign branch_target = mem_wb.alu;
	assign flush         = branch_enable; // Squash the four younger slots.

endmodule : writeback_module

`default_nettype wire

/* cpu_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath #(
	parameter lc3b_types::lc3b_word reset_pc = 16'h0000
) (
	input wire clk,
	input wire reset,
	output lc3b_types::lc3b_word mem_addr1,
	output logic mem_read1,
	input wire lc3b_types::lc3b_word mem_rdata1,
	output lc3b_types::lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	input wire lc3b_types::lc3b_word mem_rdata2,
	output lc3b_types::lc3b_word mem_wdata2
);

	import lc3b_types::*;

	lc3b_word      pc;
	if_id_payload  if_id_d;
	if_id_payload  if_id_q;
	id_ex_payload  id_ex_d;
	id_ex_payload  id_ex_q;
	ex_mem_payload ex_mem_d;
	ex_mem_payload ex_mem_q;
	ex_mem_payload ex_mem_live;
	mem_wb_payload mem_wb_d;
	mem_wb_payload mem_wb_q;

	logic          reg_we;
	logic [2:0]    reg_dest;
	lc3b_word      reg_wdata;
	logic          branch_enable;
	lc3b_word      branch_target;
	logic          flush;

	assign mem_addr1 = pc;
	assign mem_read1 = ~reset; // Fetch runs every cycle out of reset.

	assign if_id_d.ir = mem_rdata1;
	assign if_id_d.pc = pc;

	// The instruction in memory is younger than a taken branch, so its access is dropped.
	assign ex_mem_live = flush ? '0 : ex_mem_q;

	instruction_fetch #(
		.reset_pc(reset_pc)
	) u_fetch (
		.clk(clk),
		.reset(reset),
		.branch_enable(branch_enable),
		.branch_target(branch_target),
		.pc(pc)
	);

	pipe_latch #(.payload_t(if_id_payload)) u_if_id_latch (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.d(if_id_d),
		.q(if_id_q)
	);

	instruction_decode u_decode (
		.clk(clk),
		.reset(reset),
		.if_id(if_id_q),
		.reg_we(reg_we),
		.reg_dest(reg_dest),
		.reg_wdata(reg_wdata),
		.id_ex(id_ex_d)
	);

	pipe_latch #(.payload_t(id_ex_payload)) u_id_ex_latch (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.d(id_ex_d),
		.q(id_ex_q)
	);

	execution_module u_execute (
		.id_ex(id_ex_q),
		.ex_mem(ex_mem_d)
	);

	pipe_latch #(.payload_t(ex_mem_payload)) u_ex_mem_latch (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.d(ex_mem_d),
		.q(ex_mem_q)
	);

	memory_module u_memory (
		.ex_mem(ex_mem_live),
		.mem_rdata2(mem_rdata2),
		.mem_addr2(mem_addr2),
		.mem_read2(mem_read2),
		.mem_write2(mem_write2),
		.mem_wdata2(mem_wdata2),
		.mem_wb(mem_wb_d)
	);

	pipe_latch #(.payload_t(mem_wb_payload)) u_mem_wb_latch (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.d(mem_wb_d),
		.q(mem_wb_q)
	);

	writeback_module u_writeback (
		.clk(clk),
		.reset(reset),
		.mem_wb(mem_wb_q),
		.reg_we(reg_we),
		.reg_dest(reg_dest),
		.reg_wdata(reg_wdata),
		.branch_enable(branch_enable),
		.branch_target(branch_target),
		.flush(flush)
	);

endmodule : cpu_datapath

`default_nettype wire

/* cpu_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions (
	input wire clk,
	input wire reset,
	input wire lc3b_types::lc3b_word mem_addr1,
	input wire mem_read1,
	input wire lc3b_types::lc3b_word mem_addr2,
	input wire mem_read2,
	input wire mem_write2
);

	// One instruction owns the data port, so read and write never overlap.
	data_port_exclusive: assert property (@(posedge clk) mem_read2 |-> !mem_write2)
		else $error("mem_read2 and mem_write2 are high together");

	fetch_aligned: assert property (@(posedge clk) mem_read1 |-> !mem_addr1[0])
		else $error("Odd fetch address %h", mem_addr1);

	data_aligned: assert property (@(posedge clk) (mem_read2 || mem_write2) |-> !mem_addr2[0])
		else $error("Odd data address %h", mem_addr2);

	// Latches hold bubbles from the first reset edge on.
	data_quiet_in_reset: assert property (@(posedge clk)
		reset ##1 reset |-> !mem_read2 && !mem_write2)
		else $error("Data strobe is high during reset");

endmodule : cpu_assertions

bind cpu_datapath cpu_assertions u_cpu_assertions (
	.clk(clk),
	.reset(reset),
	.mem_addr1(mem_addr1),
	.mem_read1(mem_read1),
	.mem_addr2(mem_addr2),
	.mem_read2(mem_read2),
	.mem_write2(mem_write2)
);

`default_nettype wire

/* tb_cpu_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_datapath;

	import lc3b_types::*;

	typedef struct packed {
		logic [7:0] kind; // Record letter I, D or S.
		logic [7:0] test; // Index of the owning test.
		lc3b_word   addr;
		lc3b_word   data;
	} pattern_rec;

	typedef struct packed {
		lc3b_word addr;
		lc3b_word data;
	} store_rec;

	logic     clk;
	logic     reset;
	lc3b_word mem_addr1;
	logic     mem_read1;
	lc3b_word mem_rdata1;
	lc3b_word mem_addr2;
	logic     mem_read2;
	logic     mem_write2;
	lc3b_word mem_rdata2;
	lc3b_word mem_wdata2;

	lc3b_word imem [256];
	lc3b_word dmem [256];

	pattern_rec patterns[$];
	string      test_names[$];
	store_rec   expected[$]; // Stores still due in the running test.
	string      current_test;
	logic       running;
	logic       timed_out;
	int         errors;
	int         passed;
	int         failed;

	cpu_datapath #(
		.reset_pc(16'h0000)
	) u_cpu_datapath (
		.clk(clk),
		.reset(reset),
		.mem_addr1(mem_addr1),
		.mem_read1(mem_read1),
		.mem_rdata1(mem_rdata1),
		.mem_addr2(mem_addr2),
		.mem_read2(mem_read2),
		.mem_write2(mem_write2),
		.mem_rdata2(mem_rdata2),
		.mem_wdata2(mem_wdata2)
	);

	// Both ports read in the same cycle.
	assign mem_rdata1 = imem[mem_addr1[8:1]];
	assign mem_rdata2 = dmem[mem_addr2[8:1]];

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_store(input lc3b_word addr, input lc3b_word data);
		store_rec exp;
		if (expected.size() == 0) begin
			$display("Test %s stored %h at %h, but no more stores were expected",
				current_test, data, addr);
			errors++;
		end else begin
			exp = expected.pop_front();
			if (exp.addr != addr || exp.data != data) begin
				$display("Error in test %s: expected store %h at %h, got %h at %h",
					current_test, exp.data, exp.addr, data, addr);
				errors++;
			end
		end
	endtask

	always @(posedge clk) begin
		if (mem_write2) begin
			dmem[mem_addr2[8:1]] <= mem_wdata2;
			if (running)
				check_store(mem_addr2, mem_wdata2);
		end
	end

	task automatic fill_memories();
		for (int i = 0; i < 256; i++) begin
			imem[i] = {7'b0, i[7:0], 1'b0}; // BR with nzp 000 is never taken.
			dmem[i] <= {i[7:0], ~i[7:0]};
		end
	endtask

	task automatic load_patterns();
		int               fd;
		int               n;
		logic [7:0]       kind;
		logic [8*32-1:0]  name_buf;
		logic [8*128-1:0] skip_buf;
		lc3b_word         a;
		lc3b_word         d;
		pattern_rec       rec;
		fd = $fopen("cpu_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open cpu_patterns.txt");
			errors++;
			return;
		end
		while ($fscanf(fd, " %c", kind) == 1) begin
			if (kind == "#") begin
				n = $fgets(skip_buf, fd); // Comment line.
			end else if (kind == "T") begin
				n = $fscanf(fd, "%s", name_buf);
				if (n != 1) begin
					$display("Pattern file holds a test line without a name");
					errors++;
				end
				test_names.push_back(string'(name_buf));
			end else if (kind == "I" || kind == "D" || kind == "S") begin
				n = $fscanf(fd, "%h %h", a, d);
				if (n != 2) begin
					$display("Pattern file holds a %c record without an address and a word",
						kind);
					errors++;
				end
				rec.kind = kind;
				rec.test = 8'(test_names.size() - 1);
				rec.addr = a;
				rec.data = d;
				patterns.push_back(rec);
			end else begin
				$display("Pattern file holds an unknown record type %c", kind);
				errors++;
			end
		end
		$fclose(fd);
	endtask

	task automatic run_test(input int t);
		int       words;
		int       limit;
		int       cycles;
		int       halt_seen;
		int       start_errors;
		lc3b_word halt_addr;
		logic     found_halt;
		current_test = test_names[t];
		start_errors = errors;
		words        = 0;
		halt_addr    = '0;
		found_halt   = 1'b0;
		expected.delete();
		@(posedge clk);
		#1 reset = 1'b1;
		fill_memories();
		foreach (patterns[k]) begin
			if (patterns[k].test == t) begin
				if (patterns[k].kind == "I") begin
					imem[patterns[k].addr[8:1]] = patterns[k].data;
					words++;
					if (patterns[k].data == 16'h0FFF && !found_halt) begin
						halt_addr  = patterns[k].addr; // Branch-to-self ends the program.
						found_halt = 1'b1;
					end
				end else if (patterns[k].kind == "D") begin
					dmem[patterns[k].addr[8:1]] <= patterns[k].data;
				end else begin
					expected.push_back({patterns[k].addr, patterns[k].data});
				end
			end
		end
		limit = 5 * words + 50;
		@(posedge clk);
		@(posedge clk);
		if (mem_read1 !== 1'b0 || mem_read2 !== 1'b0 || mem_write2 !== 1'b0) begin
			$display("Error in test %s: strobes in reset expected 000, got %b%b%b",
				current_test, mem_read1, mem_read2, mem_write2);
			errors++;
		end
		#1 reset = 1'b0;
		running = 1'b1;
		cycles    = 0;
		halt_seen = 0;
		// The halt word is fetched once in order and again when its branch is taken.
		while (halt_seen < 2 && cycles < limit) begin
			@(posedge clk);
			if (cycles == 0 && mem_addr1 !== 16'h0000) begin
				$display("Error in test %s: first fetch address expected %h, got %h",
					current_test, 16'h0000, mem_addr1);
				errors++;
			end
			if (cycles == 0 && mem_read1 !== 1'b1) begin
				$display("Test %s: the fetch strobe stayed low after reset", current_test);
				errors++;
			end
			if (mem_read1 === 1'b1 && mem_addr1 == halt_addr)
				halt_seen++;
			cycles++;
		end
		if (halt_seen < 2) begin
			$display("Test %s timed out after %0d cycles without reaching its final loop",
				current_test, cycles);
			timed_out = 1'b1;
			errors++;
		end else begin
			repeat (10) @(posedge clk); // Spin in the loop so stray stores show up.
		end
		#1 running = 1'b0;
		if (!timed_out && expected.size() != 0) begin
			$display("Test %s ended with %0d expected stores missing",
				current_test, expected.size());
			errors++;
		end
		if (errors == start_errors) begin
			passed++;
			$display("Test %s passed", current_test);
		end else begin
			failed++;
			$display("Test %s failed with %0d errors", current_test, errors - start_errors);
		end
	endtask

	initial begin
		reset     = 1'b1;
		running   = 1'b0;
		timed_out = 1'b0;
		errors    = 0;
		passed    = 0;
		failed    = 0;
		fill_memories();
		load_patterns();
		foreach (test_names[t]) begin
			if (!timed_out)
				run_test(t);
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			test_names.size(), passed, failed, errors);
		if (errors == 0 && !timed_out && test_names.size() > 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule : tb_cpu_datapath

`default_nettype wire

/* cpu_patterns.txt */
# T name starts a test. I addr data is a program word, D addr data an initial data word.
# S addr data is an expected store, in order. All numbers are hex byte addresses and words.

T alu_ops
I 0000 1227
I 0002 143D
I 0004 0000
I 0006 0000
I 0008 1642
I 000A 5842
I 000C 5ABC
I 000E 7600
I 0010 7801
I 0012 7A02
I 0014 9C7F
I 0016 1E82
I 0018 126F
I 001A 7C03
I 001C 7E04
I 001E 7205
I 0020 0FFF
S 0000 0004
S 0002 0005
S 0004 FFFC
S 0006 FFF8
S 0008 FFFA
S 000A 0016

T load_store
I 0000 6204
I 0002 142A
I 0004 6618
I 0006 7210
I 0008 72BD
I 000A 769F
I 000C 0000
I 000E 0000
I 0010 6810
I 0012 0000
I 0014 0000
I 0016 781F
I 0018 0FFF
D 0008 1234
D 0030 BEEF
S 0020 1234
S 0004 1234
S 0048 BEEF
S 003E 1234

T branches
I 0000 1E29
I 0002 123F
I 0004 0404
I 0006 7E00
I 0008 0804
I 000A 7E01
I 000C 7E02
I 000E 7E03
I 0010 7E04
I 0012 6408
I 0014 0A04
I 0016 7E05
I 0018 6609
I 001A 0804
I 001C 7E06
I 001E 7E07
I 0020 7E08
I 0022 7E09
I 0024 1825
I 0026 0204
I 0028 760A
I 002A 760B
I 002C 760C
I 002E 760D
I 0030 760E
I 0032 780F
I 0034 0FFF
D 0010 0000
D 0012 8001
S 0000 0009
S 000A 0009
S 001C 8001
S 001E 0005

T program_end
I 0000 122C
I 0002 0000
I 0004 0000
I 0006 7201
I 0008 0FFF
I 000A 7202
I 000C 7203
S 0002 000C

/* flist.f */
lc3b_types.sv
pipe_latch.sv
instruction_fetch.sv
instruction_decode.sv
execution_module.sv
memory_module.sv
writeback_module.sv
cpu_datapath.sv
cpu_assertions.sv
tb_cpu_datapath.sv

/* Bender.yml */
package:
  name: lc3b_pipeline

sources:
  - lc3b_types.sv
  - pipe_latch.sv
  - instruction_fetch.sv
  - instruction_decode.sv
  - execution_module.sv
  - memory_module.sv
  - writeback_module.sv
  - cpu_datapath.sv
  - target: test
    files:
      - cpu_assertions.sv
      - tb_cpu_datapath.sv
